// ==== hw/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // ========================================================================
    // widths shared by every stage of the load/store end
    // ========================================================================

    localparam int WORD_BITS             = 32;
    localparam int REG_ADDR_BITS         = 5;
    localparam int REG_COUNT             = 1 << REG_ADDR_BITS;
    localparam int BYTE_LANES            = WORD_BITS / 8;
    localparam int MEM_ADDR_BITS_DEFAULT = 10;   // words, so 4 KiB of data memory

    typedef logic [WORD_BITS-1:0]     wordT;
    typedef logic [REG_ADDR_BITS-1:0] regAddrT;

    // ALU stands for any register-writing instruction that does not touch memory
    typedef enum logic [3:0]
    {
        NOP,
        ALU,
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB
    } instrT;

    // ========================================================================
    // stage records
    // ========================================================================

    typedef struct packed
    {
        logic    valid;       // one-cycle strobe per instruction
        instrT   instr;
        wordT    pc;
        wordT    addr;        // byte address computed by execute
        wordT    storeData;
        logic    regWEn;
        regAddrT regWAddr;
        wordT    aluResult;
    } memInT;

    typedef struct packed
    {
        logic       valid;
        instrT      instr;
        wordT       pc;
        logic       regWEn;
        regAddrT    regWAddr;
        wordT       aluResult;
        logic [1:0] offset;   // byte offset inside the memory word
    } wbInT;

    // the same memory word seen whole, as halfwords or as byte lanes
    typedef union packed
    {
        wordT                             word;
        logic [BYTE_LANES/2-1:0][15:0]    half;
        logic [BYTE_LANES-1:0][7:0]       bytes;
    } memWordU;

    typedef struct packed
    {
        logic    en;
        regAddrT addr;
        wordT    data;
        wordT    pc;          // carried along for the commit trace
    } grfWriteT;

endpackage

`default_nettype wire

// ==== hw/loadExtender.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadExtender (
    input  pipePkg::memWordU memWord,
    input  logic [1:0]       offset,
    input  pipePkg::instrT   instr,
    output pipePkg::wordT    extWord
);

    typedef enum logic [1:0]
    {
        UNIT_WORD,
        UNIT_HALF,
        UNIT_BYTE
    } unitT;

    unitT        unit;
    logic        signExt;
    logic [15:0] halfSel;
    logic [7:0]  byteSel;

    always_comb
    begin
        case (instr)
            pipePkg::LH, pipePkg::LHU: unit = UNIT_HALF;
            pipePkg::LB, pipePkg::LBU: unit = UNIT_BYTE;
            default:                   unit = UNIT_WORD;
        endcase
    end

    assign signExt = !(instr inside {pipePkg::LHU, pipePkg::LBU});   // unsigned loads zero-fill

    assign halfSel = memWord.half[offset[1]];   // offset bit 0 is ignored for halfwords
    assign byteSel = memWord.bytes[offset];

    always_comb
    begin
        case (unit)
            UNIT_HALF:
            begin
                extWord = {{16{signExt & halfSel[15]}}, halfSel};
            end
            UNIT_BYTE:
            begin
                extWord = {{24{signExt & byteSel[7]}}, byteSel};
            end
            default:
            begin
                extWord = memWord.word;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/memAccessStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memAccessStage #(
    parameter int MEM_ADDR_BITS = pipePkg::MEM_ADDR_BITS_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  pipePkg::memInT                  memIn,
    output logic [MEM_ADDR_BITS-1:0]        memAddr,
    output logic [pipePkg::BYTE_LANES-1:0]  byteEn,
    output pipePkg::memWordU                writeData,
    output pipePkg::wbInT                   wbIn
);

    logic [1:0]    offset;
    logic          isStore;
    pipePkg::wbInT wbNext;

    assign offset  = memIn.addr[1:0];
    assign memAddr = memIn.addr[MEM_ADDR_BITS+1:2];   // bits above the memory depth are dropped

    assign isStore = memIn.valid &&
                     (memIn.instr inside {pipePkg::SW, pipePkg::SH, pipePkg::SB});

    // ========================================================================
    // store lanes and byte enables
    // ========================================================================

    always_comb
    begin
        byteEn = '0;
        if (isStore)
        begin
            case (memIn.instr)
                pipePkg::SH: byteEn = offset[1] ? 4'b1100 : 4'b0011;
                pipePkg::SB: byteEn = 4'b0001 << offset;
                default:     byteEn = 4'b1111;
            endcase
        end
    end

    // the value is copied into every lane it could land in, byteEn picks the real one
    always_comb
    begin
        for (int lane = 0; lane < pipePkg::BYTE_LANES; lane++)
        begin
            case (memIn.instr)
                pipePkg::SB: writeData.bytes[lane] = memIn.storeData[7:0];
                pipePkg::SH: writeData.bytes[lane] = memIn.storeData[(lane % 2) * 8 +: 8];
                default:     writeData.bytes[lane] = memIn.storeData[lane * 8 +: 8];
            endcase
        end
    end

    // ========================================================================
    // write-back pipeline register
    // ========================================================================

    always_comb
    begin
        wbNext.valid     = memIn.valid;
        wbNext.instr     = memIn.instr;
        wbNext.pc        = memIn.pc;
        wbNext.regWEn    = memIn.regWEn && memIn.valid;   // idle slots never write
        wbNext.regWAddr  = memIn.regWAddr;
        wbNext.aluResult = memIn.aluResult;
        wbNext.offset    = offset;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wbIn.valid  <= 1'b0;
            wbIn.regWEn <= 1'b0;
        end
        else
        begin
            wbIn <= wbNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dataMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module dataMemory #(
    parameter int MEM_ADDR_BITS = pipePkg::MEM_ADDR_BITS_DEFAULT
) (
    input  logic                            clk,
    input  logic [MEM_ADDR_BITS-1:0]        memAddr,
    input  logic [pipePkg::BYTE_LANES-1:0]  byteEn,
    input  pipePkg::memWordU                writeData,
    output pipePkg::memWordU                readData
);

    localparam int DEPTH = 1 << MEM_ADDR_BITS;

    pipePkg::memWordU mem [DEPTH];

    // ========================================================================
    // one port, byte-lane writes, registered read
    // ========================================================================

    // written lanes are forwarded so a read at the same edge sees the new bytes
    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < pipePkg::BYTE_LANES; lane++)
        begin
            if (byteEn[lane])
            begin
                mem[memAddr].bytes[lane] <= writeData.bytes[lane];
                readData.bytes[lane]     <= writeData.bytes[lane];
            end
            else
            begin
                readData.bytes[lane] <= mem[memAddr].bytes[lane];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/writebackStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writebackStage (
    input  pipePkg::wbInT     wbIn,
    input  pipePkg::memWordU  memWord,
    output pipePkg::grfWriteT grfWrite
);

    pipePkg::wordT extWord;
    logic          isLoad;

    loadExtender i_loadExtender (
        .memWord (memWord),
        .offset  (wbIn.offset),
        .instr   (wbIn.instr),
        .extWord (extWord)
    );

    // ========================================================================
    // register-file write port
    // ========================================================================

    // LW goes through the extender too, its word path leaves the data untouched
    assign isLoad = wbIn.instr inside {pipePkg::LW, pipePkg::LH, pipePkg::LHU,
                                       pipePkg::LB, pipePkg::LBU};

    always_comb
    begin
        grfWrite.en   = wbIn.valid && wbIn.regWEn;
        grfWrite.addr = wbIn.regWAddr;
        grfWrite.pc   = wbIn.pc;

        if (isLoad)
        begin
            grfWrite.data = extWord;
        end
        else
        begin
            grfWrite.data = wbIn.aluResult;   // ALU results arrive already computed
        end
    end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::grfWriteT grfWrite,
    input  pipePkg::regAddrT  rdAddrA,
    input  pipePkg::regAddrT  rdAddrB,
    output pipePkg::wordT     rdDataA,
    output pipePkg::wordT     rdDataB
);

    // register 0 has no storage at all
    pipePkg::wordT regs [pipePkg::REG_COUNT-1:1];

    // ========================================================================
    // write port
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int r = 1; r < pipePkg::REG_COUNT; r++)
            begin
                regs[r] <= '0;
            end
        end
        else if (grfWrite.en && (grfWrite.addr != '0))
        begin
            regs[grfWrite.addr] <= grfWrite.data;
        end
    end

    // ========================================================================
    // read ports
    // ========================================================================

    // a write shows up on the read ports only after the edge that commits it
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== hw/loadStoreTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStoreTop #(
    parameter int MEM_ADDR_BITS = pipePkg::MEM_ADDR_BITS_DEFAULT
) (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::memInT    memIn,
    input  pipePkg::regAddrT  rdAddrA,
    input  pipePkg::regAddrT  rdAddrB,
    output pipePkg::wordT     rdDataA,
    output pipePkg::wordT     rdDataB,
    output pipePkg::grfWriteT grfWrite
);

    logic [MEM_ADDR_BITS-1:0]       memAddr;
    logic [pipePkg::BYTE_LANES-1:0] byteEn;
    pipePkg::memWordU               writeData;
    pipePkg::memWordU               readData;
    pipePkg::wbInT                  wbIn;

    // ========================================================================
    // memory access, one register stage deep
    // ========================================================================

    memAccessStage #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) i_memAccessStage (
        .clk       (clk),
        .rstN      (rstN),
        .memIn     (memIn),
        .memAddr   (memAddr),
        .byteEn    (byteEn),
        .writeData (writeData),
        .wbIn      (wbIn)
    );

    dataMemory #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) i_dataMemory (
        .clk       (clk),
        .memAddr   (memAddr),
        .byteEn    (byteEn),
        .writeData (writeData),
        .readData  (readData)   // lines up with wbIn, both registered at the same edge
    );

    // ========================================================================
    // write back and register file
    // ========================================================================

    writebackStage i_writebackStage (
        .wbIn     (wbIn),
        .memWord  (readData),
        .grfWrite (grfWrite)
    );

    regFile i_regFile (
        .clk      (clk),
        .rstN     (rstN),
        .grfWrite (grfWrite),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB)
    );

endmodule

`default_nettype wire

// ==== verif/loadStore_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStore_checker (
    input logic              clk,
    input logic              rstN,
    input pipePkg::memInT    memIn,
    input pipePkg::grfWriteT grfWrite,
    input pipePkg::regAddrT  rdAddrA,
    input pipePkg::regAddrT  rdAddrB,
    input pipePkg::wordT     rdDataA,
    input pipePkg::wordT     rdDataB
);

    // ========================================================================
    // register-file write port rules
    // ========================================================================

    // the write-back register is cleared by reset
    property noWriteAfterReset;
        @(posedge clk) !rstN |=> !grfWrite.en;
    endproperty

    property writeHasSource;
        @(posedge clk) disable iff (!rstN)
            grfWrite.en |-> $past(memIn.valid && memIn.regWEn);
    endproperty

    // register 0 reads zero whatever was just written to it
    property regZeroStaysZero;
        @(posedge clk) disable iff (!rstN)
            (grfWrite.en && grfWrite.addr == '0) |=>
                ((rdAddrA != '0 || rdDataA == '0) && (rdAddrB != '0 || rdDataB == '0));
    endproperty

    assert property (noWriteAfterReset)
        else $error("register write enabled in the cycle after reset");
    assert property (writeHasSource)
        else $error("register write without a valid register-writing instruction");
    assert property (regZeroStaysZero)
        else $error("register 0 read back nonzero after a write to it");

endmodule

bind loadStoreTop loadStore_checker i_loadStoreChecker (
    .clk      (clk),
    .rstN     (rstN),
    .memIn    (memIn),
    .grfWrite (grfWrite),
    .rdAddrA  (rdAddrA),
    .rdAddrB  (rdAddrB),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB)
);

`default_nettype wire

// ==== verif/loadStoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStoreTb;

    localparam int          CLK_HALF     = 2;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RESET_CYCLES = 3;
    localparam int          SEED         = 97949;
    localparam int          READ_STEPS   = pipePkg::REG_COUNT / 2;   // two registers per read
    localparam string       STIM_FILE    = "verif/loadStoreStimulus.txt";
    localparam logic [31:0] BASE_PC      = 32'h0040_0000;

    logic              clk = 1'b0;
    logic              rstN;
    pipePkg::memInT    memIn;
    pipePkg::regAddrT  rdAddrA;
    pipePkg::regAddrT  rdAddrB;
    pipePkg::wordT     rdDataA;
    pipePkg::wordT     rdDataB;
    pipePkg::grfWriteT grfWrite;

    string             testName [$];
    pipePkg::memInT    testInstr [$];
    pipePkg::wordT     testExpect [$];
    pipePkg::wordT     regModel [pipePkg::REG_COUNT];   // what each register holds at the end
    int                passCount  = 0;
    int                failCount  = 0;
    int                cycleCount = 0;
    int                cycleLimit = 0;

    loadStoreTop #(
        .MEM_ADDR_BITS (pipePkg::MEM_ADDR_BITS_DEFAULT)
    ) i_loadStoreTop (
        .clk      (clk),
        .rstN     (rstN),
        .memIn    (memIn),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .grfWrite (grfWrite)
    );

    always
    begin
        #CLK_HALF clk = !clk;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: no final result after %0d clock cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    function automatic bit writesRegister(input pipePkg::instrT op);
        return op inside {pipePkg::ALU, pipePkg::LW, pipePkg::LH, pipePkg::LHU,
                          pipePkg::LB, pipePkg::LBU};
    endfunction

    function automatic bit parseOpcode(input string text, output pipePkg::instrT op);
        op = op.first();
        for (int i = 0; i < op.num(); i++)
        begin
            if (op.name() == text)
            begin
                return 1'b1;
            end
            op = op.next();
        end
        return 1'b0;
    endfunction

    // fields an opcode ignores get random values that must not show up in the result
    function automatic pipePkg::memInT fillUnusedFields(input pipePkg::memInT slot);
        pipePkg::memInT filled;
        filled = slot;
        if (!writesRegister(slot.instr))
        begin
            filled.regWAddr = pipePkg::regAddrT'($urandom());
        end
        if (slot.instr != pipePkg::ALU)
        begin
            filled.aluResult = $urandom();
        end
        if (slot.instr inside {pipePkg::ALU, pipePkg::NOP})
        begin
            filled.addr = $urandom();
        end
        if (slot.instr == pipePkg::SB)
        begin
            filled.storeData[31:8] = 24'($urandom());   // only the low byte is stored
        end
        else if (slot.instr == pipePkg::SH)
        begin
            filled.storeData[31:16] = 16'($urandom());
        end
        else if (slot.instr != pipePkg::SW)
        begin
            filled.storeData = $urandom();
        end
        return filled;
    endfunction

    function automatic pipePkg::memInT idleSlot();
        pipePkg::memInT slot;
        slot.valid     = 1'b0;
        slot.instr     = pipePkg::instrT'($urandom_range(9, 0));
        slot.pc        = $urandom();
        slot.addr      = $urandom();
        slot.storeData = $urandom();
        slot.regWEn    = 1'($urandom());
        slot.regWAddr  = pipePkg::regAddrT'($urandom());
        slot.aluResult = $urandom();
        return slot;
    endfunction

    task automatic loadStimulus();
        int             fd;
        int             fields;
        int             lineNo;
        int             dest;
        string          line;
        string          name;
        string          opText;
        pipePkg::wordT  addr;
        pipePkg::wordT  storeData;
        pipePkg::wordT  aluValue;
        pipePkg::wordT  expectVal;
        pipePkg::instrT op;
        pipePkg::memInT entry;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("the stimulus file %s could not be opened", STIM_FILE);
            failCount++;
            return;
        end
        lineNo = 0;
        while ($fgets(line, fd) != 0)
        begin
            lineNo++;
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            fields = $sscanf(line, "%s %s %h %h %d %h %h", name, opText, addr, storeData,
                             dest, aluValue, expectVal);
            if (fields != 7 || !parseOpcode(opText, op))
            begin
                $display("stimulus line %0d is not a valid test", lineNo);
                failCount++;
                continue;
            end
            entry.valid     = 1'b1;
            entry.instr     = op;
            entry.pc        = BASE_PC + 32'(testName.size() * 4);
            entry.addr      = addr;
            entry.storeData = storeData;
            entry.regWEn    = writesRegister(op);
            entry.regWAddr  = pipePkg::regAddrT'(dest);
            entry.aluResult = aluValue;
            testName.push_back(name);
            testInstr.push_back(entry);
            testExpect.push_back(expectVal);
        end
        $fclose(fd);
    endtask

    // ========================================================================
    // compare tasks
    // ========================================================================

    task automatic checkGrfWrite(input string name, input pipePkg::grfWriteT expected,
                                 input pipePkg::grfWriteT actual);
        bit match;
        match = expected.en ? (actual === expected) : (actual.en === 1'b0);
        if (match)
        begin
            passCount++;
            $display("ok    %s en=%b rd=%0d data=%h", name, actual.en, actual.addr, actual.data);
        end
        else
        begin
            failCount++;
            $display("error %s: expected grfWrite %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkRegData(input string name, input pipePkg::wordT expected,
                                input pipePkg::wordT actual);
        if (actual === expected)
        begin
            passCount++;
            $display("ok    %s data=%h", name, actual);
        end
        else
        begin
            failCount++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial
    begin
        pipePkg::memInT    slot;
        pipePkg::grfWriteT pendExpect;
        string             pendName;
        bit                pending;
        bit                lastIdle;
        int                idx;

        void'($urandom(SEED));
        rstN         = 1'b0;
        memIn        = idleSlot();   // a live register write held through reset must be dropped
        memIn.valid  = 1'b1;
        memIn.instr  = pipePkg::ALU;
        memIn.regWEn = 1'b1;
        rdAddrA      = '0;
        rdAddrB      = '0;
        foreach (regModel[r])
        begin
            regModel[r] = '0;
        end
        loadStimulus();
        cycleLimit = 2 * (testName.size() + READ_STEPS) + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN  = 1'b1;
        memIn = '0;

        pending  = 1'b0;
        lastIdle = 1'b1;
        idx      = 0;
        while (idx < testName.size() || pending)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (pending)
            begin
                checkGrfWrite(pendName, pendExpect, grfWrite);   // strobed one edge ago
            end
            pending = 1'b0;
            // idle slots come now and then but never two in a row
            if (idx < testName.size() && (lastIdle || $urandom_range(3, 0) != 0))
            begin
                slot            = fillUnusedFields(testInstr[idx]);
                memIn           = slot;
                pendName        = testName[idx];
                pendExpect.en   = slot.regWEn;
                pendExpect.addr = slot.regWAddr;
                pendExpect.data = testExpect[idx];
                pendExpect.pc   = slot.pc;
                if (slot.regWEn && slot.regWAddr != '0)
                begin
                    regModel[slot.regWAddr] = testExpect[idx];
                end
                pending  = 1'b1;
                lastIdle = 1'b0;
                idx++;
            end
            else
            begin
                memIn    = idleSlot();
                lastIdle = 1'b1;
            end
        end

        @(posedge clk);   // the last write commits at this edge
        for (int r = 0; r < pipePkg::REG_COUNT; r += 2)
        begin
            #DRIVE_DELAY;
            rdAddrA = pipePkg::regAddrT'(r);
            rdAddrB = pipePkg::regAddrT'(r + 1);
            #DRIVE_DELAY;
            checkRegData($sformatf("reg%0d", r), regModel[r], rdDataA);
            checkRegData($sformatf("reg%0d", r + 1), regModel[r + 1], rdDataB);
            @(posedge clk);
        end

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/loadStoreStimulus.txt ====
# columns are test name, opcode, byte address, store data, rd, ALU value and expected rd value
# rd is decimal and the other numbers are hex
# columns an opcode does not use hold 0
sw_base      SW   00000100 8badf00d  0 00000000 00000000
lw_after_sw  LW   00000100 00000000  1 00000000 8badf00d
alu_pass     ALU  00000000 00000000  2 13572468 13572468
sw_bytes     SW   00000104 80ff7f01  0 00000000 00000000
lb_off0      LB   00000104 00000000  3 00000000 00000001
lb_off1      LB   00000105 00000000  4 00000000 0000007f
lb_off2      LB   00000106 00000000  5 00000000 ffffffff
lb_off3      LB   00000107 00000000  6 00000000 ffffff80
lbu_off0     LBU  00000104 00000000  7 00000000 00000001
lbu_off1     LBU  00000105 00000000  8 00000000 0000007f
lbu_off2     LBU  00000106 00000000  9 00000000 000000ff
lbu_off3     LBU  00000107 00000000 10 00000000 00000080
lh_off0      LH   00000104 00000000 11 00000000 00007f01
lh_off2      LH   00000106 00000000 12 00000000 ffff80ff
lhu_off0     LHU  00000104 00000000 13 00000000 00007f01
lhu_off2     LHU  00000106 00000000 14 00000000 000080ff
sw_merge     SW   00000108 11223344  0 00000000 00000000
sb_lane1     SB   00000109 000000aa  0 00000000 00000000
sh_upper     SH   0000010a 0000beef  0 00000000 00000000
lw_merged    LW   00000108 00000000 15 00000000 beefaa44
sb_lane3     SB   0000010b 000000c3  0 00000000 00000000
lw_merged2   LW   00000108 00000000 16 00000000 c3efaa44
alu_to_r0    ALU  00000000 00000000  0 deadbeef deadbeef
lw_to_r0     LW   00000100 00000000  0 00000000 8badf00d
nop_slot     NOP  00000000 00000000  0 00000000 00000000
alu_r3_again ALU  00000000 00000000  3 cafef00d cafef00d
lbu_r3_last  LBU  0000010b 00000000  3 00000000 000000c3

// ==== filelist.f ====
hw/pipePkg.sv
hw/loadExtender.sv
hw/memAccessStage.sv
hw/dataMemory.sv
hw/writebackStage.sv
hw/regFile.sv
hw/loadStoreTop.sv
verif/loadStore_checker.sv
verif/loadStoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= loadStoreTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
